//--- rtl/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

	localparam int clk_mhz = 25;                       // cycles per microsecond

	// bus timing in clock cycles
	localparam int power_up_cyc    = 500 * clk_mhz;
	localparam int init_strobe_cyc = 10 * clk_mhz;
	localparam int e_setup_cyc     = 1 * clk_mhz;      // e low before the pulse
	localparam int e_high_cyc      = 13 * clk_mhz;
	localparam int xfer_cyc        = 50 * clk_mhz;     // whole transfer
	localparam int clear_cyc       = 2000 * clk_mhz;   // clear and home settle

	// waits after each init strobe
	localparam int init_gaps [4] = '{50 * clk_mhz, 50 * clk_mhz, 200 * clk_mhz, 100 * clk_mhz};

	localparam int cnt_w = $clog2(clear_cyc + 1);      // longest hold fits

	// controller commands
	localparam logic [7:0] cmd_clear     = 8'h01;
	localparam logic [7:0] cmd_set_ddram = 8'h80;
	localparam logic [7:0] row_base [2]  = '{8'h00, 8'h40};

	// host control characters
	localparam logic [7:0] chr_newline  = 8'h0a;
	localparam logic [7:0] chr_formfeed = 8'h0c;

	// panel geometry
	localparam int lcd_cols = 16;
	localparam int lcd_rows = 2;
	localparam int col_w    = $clog2(lcd_cols);
	localparam int row_w    = $clog2(lcd_rows);

	// host queue
	localparam int fifo_depth = 8;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

endpackage

`default_nettype wire

//--- rtl/char_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module char_fifo import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       push,
	input  logic [7:0] wr_data,
	input  logic       pop,
	output logic [7:0] rd_data,
	output logic       empty,
	output logic       full
);

	logic [7:0]            mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0]   count;       // occupancy
	logic                  wr_en;
	logic                  rd_en;

	assign wr_en   = push && !full;
	assign rd_en   = pop && !empty;
	assign rd_data = mem[rd_ptr];       // head shown without a read cycle
	assign empty   = (count == '0);
	assign full    = (count == (fifo_ptr_w + 1)'(fifo_depth));

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two, wraps
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // both or neither
			endcase
		end
	end

	// host must respect char_full
	a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
		push |-> !full)
		else $error("char_fifo: push while full");

	// writer only pops a present entry
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> !empty)
		else $error("char_fifo: pop while empty");

endmodule

`default_nettype wire

//--- rtl/text_writer.sv
`timescale 1ns/1ns
`default_nettype none

module text_writer import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] rd_data,
	input  logic       empty,
	input  logic       busy,
	output logic       pop,
	output logic       req,
	output logic [9:0] cmd
);

	typedef enum logic [1:0] {
		st_fetch,
		st_decode,
		st_gap
	} state_t;

	state_t           state;
	logic [7:0]       ch;           // character in flight
	logic [col_w-1:0] col;
	logic [row_w-1:0] row;
	logic             need_addr;    // panel address must be set again
	logic             char_left;    // data write still owed
	logic [row_w-1:0] row_next;
	logic [7:0]       ddram_addr;

	assign row_next   = (row == row_w'(lcd_rows - 1)) ? '0 : row + 1'b1;
	assign ddram_addr = row_base[row] + 8'(col);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_fetch;
			pop       <= 1'b0;
			req       <= 1'b0;
			cmd       <= '0;
			ch        <= '0;
			col       <= '0;
			row       <= '0;
			need_addr <= 1'b1;
			char_left <= 1'b0;
		end else begin
			pop <= 1'b0;    // strobes last one cycle
			req <= 1'b0;
			case (state)
				st_fetch: begin
					if (!empty) begin
						pop   <= 1'b1;
						ch    <= rd_data;
						state <= st_decode;
					end
				end
				st_decode: begin
					if (ch == chr_newline) begin    // no bus traffic
						col       <= '0;
						row       <= row_next;
						need_addr <= 1'b1;
						state     <= st_fetch;
					end else if (!busy) begin
						req   <= 1'b1;
						state <= st_gap;
						if (ch == chr_formfeed) begin
							cmd       <= {2'b00, cmd_clear};
							col       <= '0;
							row       <= '0;
							need_addr <= 1'b1;
							char_left <= 1'b0;
						end else if (need_addr) begin
							cmd       <= {2'b00, cmd_set_ddram | ddram_addr};
							need_addr <= 1'b0;
							char_left <= 1'b1;    // come back for the data write
						end else begin
							cmd       <= {2'b10, ch};    // rs 1, rw 0
							char_left <= 1'b0;
							if (col == col_w'(lcd_cols - 1)) begin
								col       <= '0;    // wrap onto next row
								row       <= row_next;
								need_addr <= 1'b1;
							end else begin
								col <= col + 1'b1;
							end
						end
					end
				end
				// busy is not valid yet on the cycle after req
				st_gap: state <= char_left ? st_decode : st_fetch;
				default: state <= st_fetch;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/lcd_bus_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_ctrl import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [6:0] init_cfg,    // lines, font, disp, cursor, blink, inc, shift
	input  logic       req,
	input  logic [9:0] cmd,         // rs, rw, data
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data,
	output logic       busy
);

	typedef enum logic [1:0] {
		st_power,
		st_init,
		st_idle,
		st_xfer
	} state_t;

	state_t           state;
	logic [cnt_w-1:0] cnt;
	logic [1:0]       step;         // init command index
	logic             long_cmd;     // clear or home in progress
	logic [cnt_w-1:0] hold_last;

	function automatic logic [7:0] init_cmd(input logic [1:0] idx, input logic [6:0] cfg);
		logic [7:0] c;
		case (idx)
			2'd0:    c = {4'b0011, cfg[6], cfg[5], 2'b00};    // function set
			2'd1:    c = {5'b00001, cfg[4:2]};                // display control
			2'd2:    c = cmd_clear;
			default: c = {6'b000001, cfg[1:0]};               // entry mode
		endcase
		return c;
	endfunction

	assign long_cmd  = !rs && (lcd_data[7:2] == 6'd0) && (lcd_data[1:0] != 2'd0);
	assign hold_last = long_cmd ? cnt_w'(clear_cyc - 1) : cnt_w'(xfer_cyc - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_power;
			cnt      <= '0;
			step     <= '0;
			e        <= 1'b0;
			rs       <= 1'b0;
			rw       <= 1'b0;
			lcd_data <= '0;
			busy     <= 1'b1;    // panel not ready until init is done
		end else begin
			case (state)
				st_power: begin
					if (cnt == cnt_w'(power_up_cyc - 1)) begin
						cnt      <= '0;
						step     <= 2'd0;
						e        <= 1'b1;
						lcd_data <= init_cmd(2'd0, init_cfg);
						state    <= st_init;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_init: begin
					if (e) begin    // strobe phase
						if (cnt == cnt_w'(init_strobe_cyc - 1)) begin
							cnt      <= '0;
							e        <= 1'b0;
							lcd_data <= '0;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (cnt == cnt_w'(init_gaps[step] - 1)) begin
						cnt <= '0;
						if (step == 2'd3) begin
							busy  <= 1'b0;
							state <= st_idle;
						end else begin
							step     <= step + 1'b1;
							e        <= 1'b1;
							lcd_data <= init_cmd(step + 2'd1, init_cfg);
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				st_idle: begin
					if (req) begin    // no idle check, writer guarantees it
						rs       <= cmd[9];
						rw       <= cmd[8];
						lcd_data <= cmd[7:0];
						busy     <= 1'b1;
						cnt      <= '0;
						state    <= st_xfer;
					end
				end
				st_xfer: begin
					if (cnt == cnt_w'(e_setup_cyc - 1))
						e <= 1'b1;
					else if (cnt == cnt_w'(e_setup_cyc + e_high_cyc - 1))
						e <= 1'b0;
					if (cnt == hold_last) begin
						cnt      <= '0;
						busy     <= 1'b0;
						rs       <= 1'b0;    // bus parks at zero between transfers
						rw       <= 1'b0;
						lcd_data <= '0;
						state    <= st_idle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= st_power;
			endcase
		end
	end

	// writer must wait for busy to drop
	a_req_idle: assert property (@(posedge clk) disable iff (!arst_n)
		req |-> !busy)
		else $error("lcd_bus_ctrl: req while busy");

	// panel latches on the falling edge, bus must hold through the pulse
	a_bus_stable: assert property (@(posedge clk) disable iff (!arst_n)
		e && $past(e) |-> $stable({rs, rw, lcd_data}))
		else $error("lcd_bus_ctrl: bus changed while e high");

endmodule

`default_nettype wire

//--- rtl/lcd_top.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_top (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       char_push,
	input  logic [7:0] char_code,
	input  logic [6:0] init_cfg,
	output logic       char_full,
	output logic       lcd_e,
	output logic       lcd_rs,
	output logic       lcd_rw,
	output logic [7:0] lcd_data
);

	logic [7:0] fifo_data;    // queue head
	logic       fifo_empty;
	logic       fifo_pop;
	logic       bus_req;
	logic [9:0] bus_cmd;      // rs, rw, data
	logic       bus_busy;

	char_fifo u_fifo (
		.clk(clk), .arst_n(arst_n),
		.push(char_push), .wr_data(char_code), .pop(fifo_pop),
		.rd_data(fifo_data), .empty(fifo_empty), .full(char_full)
	);

	text_writer u_writer (
		.clk(clk), .arst_n(arst_n),
		.rd_data(fifo_data), .empty(fifo_empty), .busy(bus_busy),
		.pop(fifo_pop), .req(bus_req), .cmd(bus_cmd)
	);

	lcd_bus_ctrl u_bus (
		.clk(clk), .arst_n(arst_n),
		.init_cfg(init_cfg), .req(bus_req), .cmd(bus_cmd),
		.e(lcd_e), .rs(lcd_rs), .rw(lcd_rw), .lcd_data(lcd_data), .busy(bus_busy)
	);

endmodule

`default_nettype wire

//--- sim/lcd_bus_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_bus_monitor import lcd_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       e,
	input  logic       rs,
	input  logic       rw,
	input  logic [7:0] data,
	output logic       pulse_valid,    // one cycle after each e fall
	output logic [9:0] pulse_bus,      // rs, rw, data seen last while e high
	output int         high_cyc,
	output int         gap_cyc,        // low samples before the rise
	output logic       stable
);

	logic       was_high;
	logic [9:0] rise_bus;
	logic [9:0] last_bus;
	int         high_cnt;
	int         low_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			was_high    <= 1'b0;
			rise_bus    <= '0;
			last_bus    <= '0;
			high_cnt    <= 0;
			low_cnt     <= 0;
			pulse_valid <= 1'b0;
			pulse_bus   <= '0;
			high_cyc    <= 0;
			gap_cyc     <= 0;
			stable      <= 1'b1;
		end else begin
			pulse_valid <= 1'b0;
			was_high    <= e;
			low_cnt     <= e ? 0 : low_cnt + 1;
			if (e) begin
				last_bus <= {rs, rw, data};
				if (!was_high) begin    // rising edge
					rise_bus <= {rs, rw, data};
					gap_cyc  <= low_cnt;
					high_cnt <= 1;
					stable   <= 1'b1;
				end else begin
					high_cnt <= high_cnt + 1;
					if ({rs, rw, data} != rise_bus)
						stable <= 1'b0;
				end
			end else if (was_high) begin    // panel latches here
				pulse_valid <= 1'b1;
				pulse_bus   <= last_bus;
				high_cyc    <= high_cnt;
			end
		end
	end

endmodule

`default_nettype wire

//--- sim/tb_lcd_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lcd_top import lcd_pkg::*; ();

	localparam int clk_period = 4;
	localparam int n_chars    = 60;
	// init, then every transfer at the long hold
	localparam int wd_cyc     = power_up_cyc + 4 * init_strobe_cyc + 400 * clk_mhz
	                          + (n_chars * 2 + 2) * clear_cyc;

	logic       clk, arst_n, char_push, char_full;
	logic [7:0] char_code, lcd_data;
	logic [6:0] init_cfg;
	logic       lcd_e, lcd_rs, lcd_rw;
	logic       pulse_valid, bus_stable;
	logic [9:0] pulse_bus;
	int         high_cyc, gap_cyc;

	logic [31:0] lfsr = 32'hd07a;
	logic [9:0]  exp_q [$];         // expected rs, rw, data per strobe
	int          n_pulse = 0;
	int          min_gap = 0;
	int          col = 0;
	int          row = 0;
	logic        need_addr = 1'b1;
	logic        saw_full = 1'b0;

	lcd_top DUT (
		.clk(clk), .arst_n(arst_n), .char_push(char_push), .char_code(char_code),
		.init_cfg(init_cfg), .char_full(char_full), .lcd_e(lcd_e), .lcd_rs(lcd_rs),
		.lcd_rw(lcd_rw), .lcd_data(lcd_data)
	);

	lcd_bus_monitor u_mon (
		.clk(clk), .arst_n(arst_n), .e(lcd_e), .rs(lcd_rs), .rw(lcd_rw), .data(lcd_data),
		.pulse_valid(pulse_valid), .pulse_bus(pulse_bus), .high_cyc(high_cyc),
		.gap_cyc(gap_cyc), .stable(bus_stable)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // taps 32, 22, 2, 1
	endfunction

	function automatic logic [31:0] draw(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first check failure");
	endtask

	task automatic check_eq(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		if (exp_v !== act_v)
			fail_now($sformatf("Error: %s expected 0x%0h actual 0x%0h", name, exp_v, act_v));
	endtask

	task automatic model_char(input logic [7:0] c);
		if (c == chr_newline) begin
			col       = 0;
			row       = (row + 1) % lcd_rows;
			need_addr = 1'b1;
		end else if (c == chr_formfeed) begin
			exp_q.push_back({2'b00, cmd_clear});
			col       = 0;
			row       = 0;
			need_addr = 1'b1;
		end else begin
			if (need_addr)    // address first at a row start
				exp_q.push_back({2'b00, cmd_set_ddram | (row_base[row] + 8'(col))});
			need_addr = 1'b0;
			exp_q.push_back({2'b10, c});
			col++;
			if (col == lcd_cols) begin
				col       = 0;
				row       = (row + 1) % lcd_rows;
				need_addr = 1'b1;
			end
		end
	endtask

	// one push, then a quiet cycle so char_full is current again
	task automatic push_char(input logic [7:0] c);
		@(posedge clk);
		while (char_full)
			@(posedge clk);
		char_push <= 1'b1;
		char_code <= c;
		@(posedge clk);
		char_push <= 1'b0;
		model_char(c);
	endtask

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(wd_cyc * clk_period);
		fail_now("timeout, the run did not finish");
	end

	always @(posedge clk) begin
		logic [9:0] exp_bus;
		logic       long_cmd;
		if (char_full)
			saw_full <= 1'b1;
		if (pulse_valid) begin
			if (exp_q.size() == 0) begin
				fail_now("lcd_e pulse seen with no transfer expected");
			end else begin
				exp_bus  = exp_q.pop_front();
				long_cmd = !exp_bus[9] && exp_bus[7:0] >= 8'h01 && exp_bus[7:0] <= 8'h03;
				check_eq("lcd_rs", exp_bus[9], pulse_bus[9]);
				check_eq("lcd_rw", exp_bus[8], pulse_bus[8]);
				check_eq("lcd_data", exp_bus[7:0], pulse_bus[7:0]);
				check_eq("lcd_e high cycles", (n_pulse < 4) ? init_strobe_cyc : e_high_cyc,
					high_cyc);
				check_eq("lcd bus stable", 1, bus_stable);
				if (n_pulse == 0 && gap_cyc < power_up_cyc)
					check_eq("power-up wait", power_up_cyc, gap_cyc);
				else if (n_pulse > 0 && n_pulse < 4)
					check_eq("init gap", init_gaps[n_pulse - 1], gap_cyc);
				else if (n_pulse >= 4 && gap_cyc < min_gap)
					check_eq("lcd_e low gap", min_gap, gap_cyc);
				if (n_pulse < 4)
					min_gap = init_gaps[3];
				else
					min_gap = long_cmd ? clear_cyc - e_high_cyc : xfer_cyc - e_high_cyc;
				n_pulse++;
			end
		end
	end

	initial begin
		logic [7:0] c;
		int         ff_a;
		int         ff_b;
		arst_n    = 1'b0;
		char_push = 1'b0;
		char_code = '0;
		init_cfg  = draw(7);
		exp_q.push_back({2'b00, 4'b0011, init_cfg[6], init_cfg[5], 2'b00});
		exp_q.push_back({2'b00, 5'b00001, init_cfg[4:2]});
		exp_q.push_back({2'b00, cmd_clear});
		exp_q.push_back({2'b00, 6'b000001, init_cfg[1:0]});
		ff_a = 8 + draw(4);    // two form feeds somewhere in the stream
		ff_b = 32 + draw(4);
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		for (int i = 0; i < n_chars; i++) begin
			if (i == ff_a || i == ff_b)
				c = chr_formfeed;
			else if (draw(3) == 0)
				c = chr_newline;
			else
				c = 8'h20 + 8'(draw(7) % 95);
			push_char(c);
			if (draw(2) != 0)    // otherwise burst
				repeat (draw(6)) @(posedge clk);
		end
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (clear_cyc) @(posedge clk);    // bus settles, no stray strobes
		check_eq("lcd_e idle", 0, lcd_e);
		check_eq("lcd_data idle", 0, {lcd_rs, lcd_rw, lcd_data});
		check_eq("char_full seen", 1, saw_full);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
rtl/lcd_pkg.sv
rtl/char_fifo.sv
rtl/text_writer.sv
rtl/lcd_bus_ctrl.sv
rtl/lcd_top.sv
sim/lcd_bus_monitor.sv
sim/tb_lcd_top.sv
